// File: Bender.yml
package:
  name: redun_mont

sources:
  - files:
      - rtl/redun_mont_pkg.sv
      - rtl/redun_async_fifo.sv
      - rtl/redun_reset_sync.sv
      - rtl/redun_square.sv
      - rtl/redun_mont_reduce.sv
      - rtl/redun_mont_top.sv
  - target: test
    files:
      - tests/redun_mont_checker.sv
      - tests/tb_redun_mont.sv

// File: rtl/redun_async_fifo.sv
`timescale 1ns/10ps

module redun_async_fifo #(
  parameter int FIFO_DEPTH = 16                 // Power of two, 4 or more
) (
  input  logic                    i_wr_clk,
  input  logic                    i_rd_clk,
  input  logic                    i_reset,
  input  logic                    i_wr_en,
  input  redun_mont_pkg::redun0_t i_din,
  output redun_mont_pkg::redun0_t o_dout,
  output logic                    o_val
);
  import redun_mont_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);       // Address bits, pointers carry one more

  function automatic logic [AW:0] bin2gray(input logic [AW:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  redun0_t mem [FIFO_DEPTH];                    // Storage, one operand per entry

  logic [AW:0] wr_bin, wr_bin_nxt, wr_gray;     // Write side pointers
  logic [AW:0] rd_bin, rd_bin_nxt, rd_gray;     // Read side pointers
  logic [AW:0] rd_gray_s1, rd_gray_s2;          // Read ptr seen by writer
  logic [AW:0] wr_gray_s1, wr_gray_s2;          // Write ptr seen by reader
  logic        wr_full;
  logic        wr_go;
  logic        rd_pop;
  redun0_t     dout_q;                          // RAM read register
  logic [1:0]  val_q;                           // Valid delay line

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write domain
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Full when top two Gray bits differ and the rest match
  assign wr_full    = (wr_gray == {~rd_gray_s2[AW:AW-1], rd_gray_s2[AW-2:0]});
  assign wr_go      = i_wr_en & ~wr_full;      // Overrun is dropped, never wraps
  assign wr_bin_nxt = wr_bin + 1'b1;

  always_ff @(posedge i_wr_clk) begin
    if (i_reset) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;                    // Two flop sync
      rd_gray_s2 <= rd_gray_s1;
      if (wr_go) begin
        wr_bin  <= wr_bin_nxt;
        wr_gray <= bin2gray(wr_bin_nxt);        // Registered Gray, glitch free crossing
      end
    end
  end

  always_ff @(posedge i_wr_clk) begin
    if (wr_go) mem[wr_bin[AW-1:0]] <= i_din;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read domain
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign rd_pop     = (rd_gray != wr_gray_s2); // Pops on its own whenever not empty
  assign rd_bin_nxt = rd_bin + 1'b1;

  always_ff @(posedge i_rd_clk) begin
    if (i_reset) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
      val_q      <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
      val_q      <= {val_q[0], rd_pop};        // Line up with second data register
      if (rd_pop) begin
        rd_bin  <= rd_bin_nxt;
        rd_gray <= bin2gray(rd_bin_nxt);
      end
    end
  end

  // Payload path, no reset
  always_ff @(posedge i_rd_clk) begin
    dout_q <= mem[rd_bin[AW-1:0]];              // Entry at head, used when pop was high
    o_dout <= dout_q;
  end

  assign o_val = val_q[1];                      // Read latency 2

endmodule

// File: rtl/redun_mont_pkg.sv
package redun_mont_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operand geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int NUM_WRDS  = 4;                     // Words per operand
  localparam int WRD_BITS  = 8;                     // Value bits per word
  localparam int MONT_BITS = NUM_WRDS * WRD_BITS;   // R = 2**MONT_BITS

  // One redundant word, bit WRD_BITS is the carry
  // Carry of word i has the weight of word i+1 bit 0
  typedef logic [WRD_BITS:0] redun_wrd_t;

  // Word 0 least significant
  typedef redun_wrd_t [NUM_WRDS-1:0] redun0_t;

  // Full square of a normalized operand
  // Normalized value may need one bit above MONT_BITS, so two extra bits here
  typedef logic [2*MONT_BITS+1:0] mont_prod_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Montgomery constant
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Returns -modulus**-1 mod 2**WRD_BITS
  // Newton step x <- x*(2 - m*x) doubles the number of correct low bits
  // Seed x = m is already right to 3 bits for any odd m
  function automatic logic [WRD_BITS-1:0] mont_ninv(input logic [MONT_BITS-1:0] modulus);
    logic [WRD_BITS-1:0] m_lo;
    logic [WRD_BITS-1:0] inv;
    logic [WRD_BITS-1:0] corr;
    m_lo = modulus[WRD_BITS-1:0];
    inv  = m_lo;
    for (int prec = 3; prec < WRD_BITS; prec = prec * 2) begin
      corr = WRD_BITS'(2) - WRD_BITS'(m_lo * inv);  // 2 - m*x, wraps mod word
      inv  = WRD_BITS'(inv * corr);
    end
    return WRD_BITS'(0) - inv;                      // Negate mod 2**WRD_BITS
  endfunction

endpackage

// File: rtl/redun_mont_reduce.sv
`timescale 1ns/10ps

module redun_mont_reduce #(
  parameter logic [redun_mont_pkg::MONT_BITS-1:0] MODULUS = 32'hFFFF_FFC5  // Odd
) (
  input  logic                       clk_int,
  input  logic                       i_reset,
  input  logic                       i_val,
  input  redun_mont_pkg::mont_prod_t i_prod,
  output logic                       o_val,
  output redun_mont_pkg::redun0_t    o_mul
);
  import redun_mont_pkg::*;

  localparam int                  SUM_BITS = $bits(mont_prod_t) + 1;  // Room for T + q*M
  localparam logic [WRD_BITS-1:0] NINV     = mont_ninv(MODULUS);     // -M**-1 mod word

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Word serial reduction, one stage per word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar g = 0; g < NUM_WRDS; g++) begin : g_stage
    mont_prod_t          t_in;   // Stage input
    logic                v_in;
    logic [WRD_BITS-1:0] q;      // Makes the low word vanish
    logic [SUM_BITS-1:0] t_sum;
    mont_prod_t          t_q;    // Stage register
    logic                v_q;

    if (g == 0) begin : g_first
      assign t_in = i_prod;
      assign v_in = i_val;
    end else begin : g_next
      assign t_in = g_stage[g-1].t_q;
      assign v_in = g_stage[g-1].v_q;
    end

    assign q     = WRD_BITS'(t_in[WRD_BITS-1:0] * NINV);
    assign t_sum = SUM_BITS'(t_in) + SUM_BITS'(q * MODULUS);  // Low word now zero

    always_ff @(posedge clk_int) begin
      if (i_reset) begin
        v_q <= 1'b0;
      end else begin
        v_q <= v_in;
      end
    end

    always_ff @(posedge clk_int) begin
      t_q <= mont_prod_t'(t_sum >> WRD_BITS);  // Exact divide by 2**WRD_BITS
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Final subtract and word split
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  mont_prod_t           t_fin;   // Below 2*MODULUS here
  logic [MONT_BITS-1:0] res_q;

  assign t_fin = g_stage[NUM_WRDS-1].t_q;

  always_ff @(posedge clk_int) begin
    if (i_reset) begin
      o_val <= 1'b0;
    end else begin
      o_val <= g_stage[NUM_WRDS-1].v_q;
    end
  end

  always_ff @(posedge clk_int) begin
    if (t_fin >= MODULUS) begin
      res_q <= MONT_BITS'(t_fin - MODULUS);   // One subtract is enough
    end else begin
      res_q <= MONT_BITS'(t_fin);
    end
  end

  // Canonical words, carry bits zero
  always_comb begin
    for (int i = 0; i < NUM_WRDS; i++) begin
      o_mul[i] = {1'b0, res_q[i*WRD_BITS +: WRD_BITS]};
    end
  end

endmodule

// File: rtl/redun_mont_top.sv
`timescale 1ns/10ps

module redun_mont_top #(
  parameter logic [redun_mont_pkg::MONT_BITS-1:0] MODULUS = 32'hFFFF_FFC5,
  parameter int FIFO_DEPTH  = 16,
  parameter int SYNC_STAGES = 3
) (
  input  logic                    clk_io,     // Host clock
  input  logic                    clk_int,    // Core clock, faster than clk_io
  input  logic                    i_reset,
  input  logic                    i_start,    // One operand per high cycle
  input  redun_mont_pkg::redun0_t i_sq_in,
  output redun_mont_pkg::redun0_t o_sq_out,
  output logic                    o_valid,    // One cycle per result
  output logic                    o_ready
);
  import redun_mont_pkg::*;

  logic       reset_int;   // Core reset, clk_int
  logic       fifo_rst;    // Held across both domains
  logic       in_wr;
  redun0_t    sq_in;       // Operand in core domain
  logic       in_val;
  mont_prod_t prod;        // Square to reducer
  logic       prod_val;
  redun0_t    mul_o;       // Result in core domain
  logic       mul_val;

  assign fifo_rst = i_reset | reset_int;
  assign in_wr    = i_start & o_ready;        // Operands before ready are lost

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reset and clock crossing in
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  redun_reset_sync #(
    .SYNC_STAGES ( SYNC_STAGES )
  ) u_reset_sync (
    .clk_io      ( clk_io      ),
    .clk_int     ( clk_int     ),
    .i_reset     ( i_reset     ),
    .o_reset_int ( reset_int   ),
    .o_ready     ( o_ready     )
  );

  redun_async_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_fifo_in (
    .i_wr_clk ( clk_io   ),
    .i_rd_clk ( clk_int  ),
    .i_reset  ( fifo_rst ),
    .i_wr_en  ( in_wr    ),
    .i_din    ( i_sq_in  ),
    .o_dout   ( sq_in    ),
    .o_val    ( in_val   )
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Core, 7 cycles fixed
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  redun_square u_square (
    .clk_int ( clk_int   ),
    .i_reset ( reset_int ),
    .i_val   ( in_val    ),
    .i_sq    ( sq_in     ),
    .o_val   ( prod_val  ),
    .o_prod  ( prod      )
  );

  redun_mont_reduce #(
    .MODULUS ( MODULUS )
  ) u_reduce (
    .clk_int ( clk_int   ),
    .i_reset ( reset_int ),
    .i_val   ( prod_val  ),
    .i_prod  ( prod      ),
    .o_val   ( mul_val   ),
    .o_mul   ( mul_o     )
  );

  // Back to host clock
  redun_async_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_fifo_out (
    .i_wr_clk ( clk_int  ),
    .i_rd_clk ( clk_io   ),
    .i_reset  ( fifo_rst ),
    .i_wr_en  ( mul_val  ),
    .i_din    ( mul_o    ),
    .o_dout   ( o_sq_out ),
    .o_val    ( o_valid  )
  );

endmodule

// File: rtl/redun_reset_sync.sv
`timescale 1ns/10ps

module redun_reset_sync #(
  parameter int SYNC_STAGES = 3
) (
  input  logic clk_io,
  input  logic clk_int,
  input  logic i_reset,       // Synchronous to clk_io
  output logic o_reset_int,   // Core reset in clk_int
  output logic o_ready        // Host side, operands accepted when high
);

  logic [SYNC_STAGES-1:0] int_chain;  // clk_int chain
  logic [SYNC_STAGES-1:0] io_chain;   // clk_io chain, carries release back

  // Reset crosses into core clock, falls SYNC_STAGES edges after i_reset
  always_ff @(posedge clk_int) begin
    int_chain <= {int_chain[SYNC_STAGES-2:0], i_reset};
  end

  assign o_reset_int = int_chain[SYNC_STAGES-1];

  // Released core reset returns to clk_io as ready
  always_ff @(posedge clk_io) begin
    if (i_reset) begin
      io_chain <= '0;                 // Ready drops at once on a new reset
    end else begin
      io_chain <= {io_chain[SYNC_STAGES-2:0], ~o_reset_int};
    end
  end

  assign o_ready = io_chain[SYNC_STAGES-1];

endmodule

// File: rtl/redun_square.sv
`timescale 1ns/10ps

module redun_square (
  input  logic                       clk_int,
  input  logic                       i_reset,
  input  logic                       i_val,
  input  redun_mont_pkg::redun0_t    i_sq,
  output logic                       o_val,
  output redun_mont_pkg::mont_prod_t o_prod
);
  import redun_mont_pkg::*;

  logic [MONT_BITS:0] norm_c;  // Exact value of the operand
  logic [MONT_BITS:0] norm_q;
  logic               val_q;   // Stage 1 valid
  mont_prod_t         prod_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Carry fold
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Digit i = value bits of word i + carry bit of word i-1 + ripple
  // Sum per digit is at most 2**WRD_BITS + 1, so ripple stays one bit
  always_comb begin : fold
    logic [WRD_BITS:0] dig;
    logic              ripple;
    logic              cin;
    ripple = 1'b0;
    for (int i = 0; i < NUM_WRDS; i++) begin
      cin = (i == 0) ? 1'b0 : i_sq[(i == 0) ? 0 : i-1][WRD_BITS];
      dig = {1'b0, i_sq[i][WRD_BITS-1:0]} + cin + ripple;
      norm_c[i*WRD_BITS +: WRD_BITS] = dig[WRD_BITS-1:0];
      ripple = dig[WRD_BITS];
    end
    // Top carry and ripple never both set for an operand below the modulus
    norm_c[MONT_BITS] = i_sq[NUM_WRDS-1][WRD_BITS] | ripple;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pipeline
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_int) begin
    if (i_reset) begin
      val_q <= 1'b0;
      o_val <= 1'b0;
    end else begin
      val_q <= i_val;                     // Cycle 1 normalize
      o_val <= val_q;                     // Cycle 2 square
    end
  end

  always_ff @(posedge clk_int) begin
    norm_q <= norm_c;
    prod_q <= norm_q * norm_q;            // Full double width square
  end

  assign o_prod = prod_q;

endmodule

// File: tests/redun_mont_checker.sv
`timescale 1ns/10ps

module redun_mont_checker #(
  parameter logic [redun_mont_pkg::MONT_BITS-1:0] MODULUS = 32'hFFFF_FFC5
) (
  input  logic                    clk_io,
  input  logic                    i_reset,
  input  logic                    i_start,    // Host strobe, seen beside the DUT
  input  redun_mont_pkg::redun0_t i_sq_in,
  input  logic                    i_ready,    // DUT o_ready
  input  logic                    i_valid,    // DUT o_valid
  input  redun_mont_pkg::redun0_t i_sq_out,   // DUT o_sq_out
  output int                      o_checked,
  output int                      o_errors,
  output int                      o_pending
);
  import redun_mont_pkg::*;

  localparam int RW = 2*MONT_BITS + 4;        // Square plus room for adding the modulus

  redun0_t exp_q[$];                          // Expected results, input order
  redun0_t exp;
  int      checked = 0;
  int      errors  = 0;
  int      pending = 0;

  assign o_checked = checked;
  assign o_errors  = errors;
  assign o_pending = pending;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // x*x*2**-MONT_BITS mod MODULUS, one bit per round
  function automatic logic [MONT_BITS-1:0] mont_sq_ref(input redun0_t op);
    logic [RW-1:0] x;
    logic [RW-1:0] t;
    x = '0;
    for (int i = 0; i < NUM_WRDS; i++) begin
      x = x + (RW'(op[i][WRD_BITS-1:0]) << (i*WRD_BITS));   // Value bits
      x = x + (RW'(op[i][WRD_BITS]) << ((i+1)*WRD_BITS));   // Carry weighs one of next word
    end
    t = x * x;
    for (int r = 0; r < MONT_BITS; r++) begin
      if (t[0]) t = t + RW'(MODULUS);         // Make it even, value mod M unchanged
      t = t >> 1;                             // Times 2**-1 mod M
    end
    if (t >= RW'(MODULUS)) t = t - RW'(MODULUS);
    return t[MONT_BITS-1:0];
  endfunction

  // Canonical words, all carries clear
  function automatic redun0_t split_words(input logic [MONT_BITS-1:0] v);
    redun0_t w;
    for (int i = 0; i < NUM_WRDS; i++) w[i] = {1'b0, v[i*WRD_BITS +: WRD_BITS]};
    return w;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare, mid cycle where everything is settled
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk_io) begin
    if (i_reset) begin
      if (exp_q.size() != 0) $display("Reset at %0t dropped %0d results", $time, exp_q.size());
      exp_q.delete();                          // In flight work is gone
    end else begin
      if (i_valid) begin
        if (exp_q.size() == 0) begin
          $display("Result at %0t arrived with no operand outstanding", $time);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          checked++;
          if (i_sq_out !== exp) begin
            $display("ERR %0t o_sq_out expected %h actual %h", $time, exp, i_sq_out);
            errors++;
          end
        end
      end
      if (i_start && i_ready) exp_q.push_back(split_words(mont_sq_ref(i_sq_in)));  // Accepted op
    end
    pending = exp_q.size();
  end

endmodule

// File: tests/tb_redun_mont.sv
`timescale 1ns/10ps

module tb_redun_mont;
  import redun_mont_pkg::*;

  localparam logic [MONT_BITS-1:0] MODULUS = 32'hFFFF_FFC5;
  localparam int FIFO_DEPTH  = 16;
  localparam int SYNC_STAGES = 3;
  localparam int N_RAND      = 200;
  localparam int N_PRE       = 12;                      // Ops cut off by mid stream reset
  localparam int N_POST      = 20;
  localparam int N_OPS       = 4 + 8 + N_RAND + N_PRE + N_POST;
  localparam int TIMEOUT_CYC = 40*N_OPS + 200;          // clk_io cycles
  localparam int READY_LIMIT = 16;                      // Both sync chains plus margin

  logic    clk_io, clk_int, i_reset, i_start, o_valid, o_ready;
  redun0_t i_sq_in, o_sq_out;
  integer  seed = 32'ha3c0;
  int      tb_errors = 0;
  int      cycle_cnt;
  int      chk_checked, chk_errors, chk_pending;

  initial begin
    clk_int = 1'b0;
    forever #4 clk_int = ~clk_int;                      // 8 ns core clock
  end

  initial begin
    clk_io = 1'b0;
    forever #5 clk_io = ~clk_io;                        // 10 ns host clock
  end

  redun_mont_top #(
    .MODULUS     ( MODULUS     ),
    .FIFO_DEPTH  ( FIFO_DEPTH  ),
    .SYNC_STAGES ( SYNC_STAGES )
  ) i_dut (
    .clk_io  ( clk_io  ), .clk_int ( clk_int ), .i_reset ( i_reset  ), .i_start ( i_start ),
    .i_sq_in ( i_sq_in ), .o_sq_out ( o_sq_out ), .o_valid ( o_valid ), .o_ready ( o_ready )
  );

  redun_mont_checker #(.MODULUS(MODULUS)) u_chk (
    .clk_io   ( clk_io   ), .i_reset   ( i_reset     ), .i_start   ( i_start    ),
    .i_sq_in  ( i_sq_in  ), .i_ready   ( o_ready     ), .i_valid   ( o_valid    ),
    .i_sq_out ( o_sq_out ), .o_checked ( chk_checked ), .o_errors  ( chk_errors ),
    .o_pending ( chk_pending )
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers, all start and end 1 ns after a clk_io edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Borrow one from word i+1 to set the carry of word i
  function automatic redun0_t to_redun(input logic [MONT_BITS-1:0] x,
                                       input logic [NUM_WRDS-2:0] mask);
    redun0_t w;
    for (int i = 0; i < NUM_WRDS; i++) w[i] = {1'b0, x[i*WRD_BITS +: WRD_BITS]};
    for (int i = 0; i < NUM_WRDS-1; i++) begin
      if (mask[i] && (w[i+1][WRD_BITS-1:0] != 0)) begin  // Only where the next word can lend
        w[i+1][WRD_BITS-1:0] = w[i+1][WRD_BITS-1:0] - 1'b1;
        w[i][WRD_BITS]       = 1'b1;
      end
    end
    return w;
  endfunction

  function automatic logic [MONT_BITS-1:0] rand_operand();
    logic [MONT_BITS-1:0] r;
    r = $random(seed);
    return r % MODULUS;                                 // Operand must stay below M
  endfunction

  task automatic drive_op(input redun0_t v);
    i_sq_in = v;
    i_start = 1'b1;
    @(posedge clk_io);
    #1;
  endtask

  task automatic rand_burst(input int n);
    logic [NUM_WRDS-2:0] mask;
    for (int k = 0; k < n; k++) begin
      mask = $random(seed);
      drive_op(to_redun(rand_operand(), mask));         // Back to back strobes
    end
    i_start = 1'b0;
  endtask

  // Reset for 8 cycles, then wait for ready with o_valid held low
  task automatic reset_dut();
    int n;
    i_start = 1'b0;
    i_reset = 1'b1;
    for (int c = 0; c < 8; c++) begin
      @(posedge clk_io);
      #1;
      if (o_valid || o_ready) begin
        $display("o_valid or o_ready high during reset at %0t", $time);
        tb_errors++;
      end
    end
    i_reset = 1'b0;
    n = 0;
    while (!o_ready && n < READY_LIMIT) begin
      if (o_valid) begin
        $display("Stale result at %0t before o_ready", $time);
        tb_errors++;
      end
      @(posedge clk_io);
      #1;
      n++;
    end
    if (!o_ready) begin
      $display("o_ready did not rise within %0d cycles after reset", READY_LIMIT);
      tb_errors++;
    end
  endtask

  // Wait until every accepted operand has its result
  task automatic wait_drain(input int n_sent, input int base_chk);
    int n;
    n = 0;
    while (chk_pending != 0 && n < 400) begin
      @(posedge clk_io);
      #1;
      n++;
    end
    if (chk_pending != 0) begin
      $display("%0d results missing after %0d cycles", chk_pending, n);
      tb_errors++;
    end
    if (chk_checked - base_chk != n_sent) begin
      $display("Got %0d results for %0d operands", chk_checked - base_chk, n_sent);
      tb_errors++;
    end
  endtask

  task automatic end_test(input string name, input int base_err);
    $display("test %-10s done, %0d errors", name, tb_errors + chk_errors - base_err);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : main
    logic [MONT_BITS-1:0] vals [4];
    int                   base_err;
    int                   base_chk;
    i_reset = 1'b1;
    i_start = 1'b0;
    i_sq_in = '0;
    vals    = '{32'h0100_0100, 32'h1234_5678, MODULUS - 1, 32'h8001_0203};

    reset_dut();                                        // 1 reset and ready
    end_test("reset", 0);

    base_err = tb_errors + chk_errors;                  // 2 canonical corners
    base_chk = chk_checked;
    drive_op(to_redun(32'd0, '0));
    drive_op(to_redun(32'd1, '0));
    drive_op(to_redun(32'd2, '0));
    drive_op(to_redun(MODULUS - 1, '0));
    i_start = 1'b0;
    wait_drain(4, base_chk);
    end_test("canonical", base_err);

    base_err = tb_errors + chk_errors;                  // 3 canonical then redundant form
    base_chk = chk_checked;
    foreach (vals[k]) begin
      drive_op(to_redun(vals[k], '0));
      drive_op(to_redun(vals[k], '1));
    end
    i_start = 1'b0;
    wait_drain(8, base_chk);
    end_test("redundant", base_err);

    base_err = tb_errors + chk_errors;                  // 4 random burst
    base_chk = chk_checked;
    rand_burst(N_RAND);
    wait_drain(N_RAND, base_chk);
    end_test("random", base_err);

    base_err = tb_errors + chk_errors;                  // 5 reset mid stream
    rand_burst(N_PRE);
    reset_dut();                                        // Checker drops its queue here
    repeat (20) @(posedge clk_io);                      // Any result now is stale
    #1;
    base_chk = chk_checked;
    rand_burst(N_POST);
    wait_drain(N_POST, base_chk);
    end_test("midreset", base_err);

    $display("Checked %0d results, %0d errors", chk_checked, tb_errors + chk_errors);
    if (tb_errors + chk_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYC) begin
      @(posedge clk_io);
      cycle_cnt++;
    end
    $display("Run stopped after %0d clk_io cycles without finishing", cycle_cnt);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: vlog.f
rtl/redun_mont_pkg.sv
rtl/redun_async_fifo.sv
rtl/redun_reset_sync.sv
rtl/redun_square.sv
rtl/redun_mont_reduce.sv
rtl/redun_mont_top.sv
tests/redun_mont_checker.sv
tests/tb_redun_mont.sv
